// File: Makefile
# Verilator build and run for the HyperRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_hyper
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
+incdir+rtl
rtl/hyper_pkg.sv
rtl/hyper_seq_fsm.sv
rtl/hyper_phase_timer.sv
rtl/hyper_tx_shift.sv
rtl/hyper_rx_capture.sv
rtl/hyper_io_regs.sv
rtl/hyper_ctrl.sv
testbench/tb_clock.sv
testbench/hyperram_model.sv
testbench/tb_hyper.sv

// File: rtl/hyper_cfg.svh
// HyperRAM controller sizes: byte counts, field widths and the read wait
`ifndef HYPER_CFG_SVH
`define HYPER_CFG_SVH

// Command-address bytes sent at the start of every transaction
`define HYPER_CA_BYTES 6
// Bytes per core dword
`define HYPER_DWORD_BYTES 4
// Register writes carry one 16-bit value
`define HYPER_REG_BYTES 2

// Latency inputs and phase countdown width
`define HYPER_LAT_W 6
// Read dword count width, 1 to 63 dwords
`define HYPER_DWORDS_W 6

// Ticks allowed for the RWDS strobe before each read dword
`define HYPER_READ_WAIT 63

`endif

// File: rtl/hyper_ctrl.sv
// HyperRAM controller top: sequencer, phase timer, shifters, capture and pad registers
`timescale 1ns/1ns
`include "hyper_cfg.svh"

module hyper_ctrl (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req_valid,
  input  hyper_pkg::hyper_req_t             req,
  input  logic [`HYPER_LAT_W-1:0]           latency_1x,
  input  logic [`HYPER_LAT_W-1:0]           latency_2x,
  output logic [`HYPER_DWORD_BYTES*8-1:0]   rd_d,
  output logic                              rd_rdy,
  output logic                              busy,
  output hyper_pkg::hyper_pad_tx_t          pad_tx,
  input  hyper_pkg::hyper_pad_rx_t          pad_rx
);

  // Strobes arriving while busy are dropped
  logic                       req_accept;
  // Sequencer to timer
  logic                       load;
  logic [`HYPER_LAT_W-1:0]    count;
  logic                       run;
  logic                       phase_tick;
  logic                       expired;
  logic                       ck_level;
  // Sequencer to datapath
  logic                       shift_ca;
  logic                       shift_data;
  logic                       read_run;
  logic                       dq_oe_l;
  logic                       rwds_oe_l;
  logic                       cs;
  // Datapath to pads and back
  logic [7:0]                 tx_byte;
  logic                       tx_mask;
  logic [7:0]                 rx_dq;
  logic                       rx_rwds;
  logic                       dword_done;

  assign req_accept = req_valid & ~busy;
  // rd_d is loaded together with dword_done
  assign rd_rdy = dword_done;

  hyper_seq_fsm u_seq (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_accept),
    .op          (req.op),
    .num_dwords  (req.num_dwords),
    .latency_1x  (latency_1x),
    .latency_2x  (latency_2x),
    .rwds_sample (rx_rwds),
    .phase_tick  (phase_tick),
    .expired     (expired),
    .dword_done  (dword_done),
    .load        (load),
    .count       (count),
    .run         (run),
    .shift_ca    (shift_ca),
    .shift_data  (shift_data),
    .read_run    (read_run),
    .dq_oe_l     (dq_oe_l),
    .rwds_oe_l   (rwds_oe_l),
    .cs          (cs),
    .busy        (busy)
  );

  hyper_phase_timer u_timer (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .load       (load),
    .count      (count),
    .phase_tick (phase_tick),
    .expired    (expired),
    .ck_level   (ck_level)
  );

  hyper_tx_shift u_tx (
    .clk        (clk),
    .req_valid  (req_accept),
    .req        (req),
    .shift_ca   (shift_ca),
    .shift_data (shift_data),
    .tx_byte    (tx_byte),
    .tx_mask    (tx_mask)
  );

  hyper_rx_capture u_rx (
    .clk        (clk),
    .read_run   (read_run),
    .rwds       (rx_rwds),
    .dq         (rx_dq),
    .rd_d       (rd_d),
    .dword_done (dword_done)
  );

  hyper_io_regs u_io (
    .clk       (clk),
    .reset     (reset),
    .ck_level  (ck_level),
    .cs        (cs),
    .tx_byte   (tx_byte),
    .tx_mask   (tx_mask),
    .dq_oe_l   (dq_oe_l),
    .rwds_oe_l (rwds_oe_l),
    .pad_rx    (pad_rx),
    .pad_tx    (pad_tx),
    .rx_dq     (rx_dq),
    .rx_rwds   (rx_rwds)
  );

endmodule

// File: rtl/hyper_io_regs.sv
// Pad output and input flops, DRAM clock, chip select and device reset
`timescale 1ns/1ns

module hyper_io_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ck_level,
  input  logic                      cs,
  input  logic [7:0]                tx_byte,
  input  logic                      tx_mask,
  input  logic                      dq_oe_l,
  input  logic                      rwds_oe_l,
  input  hyper_pkg::hyper_pad_rx_t  pad_rx,
  output hyper_pkg::hyper_pad_tx_t  pad_tx,
  output logic [7:0]                rx_dq,
  output logic                      rx_rwds
);

  logic       ck_d;
  logic       ck_q;
  logic [7:0] dq_q;
  logic       rwds_q;
  logic       dq_oe_l_q;
  logic       rwds_oe_l_q;
  logic       cs_l_q;

  // Two flops on the clock put its edges mid data byte
  always_ff @(posedge clk) begin
    ck_d    <= ck_level;
    ck_q    <= ck_d;
    dq_q    <= tx_byte;
    // RWDS high masks the byte
    rwds_q  <= ~tx_mask;
    rx_dq   <= pad_rx.dq;
    rx_rwds <= pad_rx.rwds;
  end

  // Pads default to input with CS released
  always_ff @(posedge clk) begin
    if (reset) begin
      dq_oe_l_q   <= 1'b1;
      rwds_oe_l_q <= 1'b1;
      cs_l_q      <= 1'b1;
    end else begin
      dq_oe_l_q   <= dq_oe_l;
      rwds_oe_l_q <= rwds_oe_l;
      cs_l_q      <= ~cs;
    end
  end

  assign pad_tx = '{
    dq:        dq_q,
    dq_oe_l:   dq_oe_l_q,
    rwds:      rwds_q,
    rwds_oe_l: rwds_oe_l_q,
    ck:        ck_q,
    cs_l:      cs_l_q,
    rst_l:     ~reset
  };

endmodule

// File: rtl/hyper_phase_timer.sv
// DRAM clock phase counter and phase countdown timer
`timescale 1ns/1ns
`include "hyper_cfg.svh"

module hyper_phase_timer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        run,
  input  logic                        load,
  input  logic [`HYPER_LAT_W-1:0]     count,
  output logic                        phase_tick,
  output logic                        expired,
  output logic                        ck_level
);

  // Four fabric cycles per DRAM clock
  logic [1:0]                 phase;
  logic [`HYPER_LAT_W-1:0]    remain;

  always_ff @(posedge clk) begin
    if (reset || !run) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;
    end
  end

  // Countdown in half DRAM clocks, load wins over the decrement
  always_ff @(posedge clk) begin
    if (reset) begin
      remain <= '0;
    end else if (load) begin
      remain <= count;
    end else if (phase_tick && remain != '0) begin
      remain <= remain - `HYPER_LAT_W'(1);
    end
  end

  // Odd phases, one byte slot each
  assign phase_tick = phase[0];
  assign expired    = phase_tick && (remain == `HYPER_LAT_W'(1));
  assign ck_level   = phase[1];

endmodule

// File: rtl/hyper_pkg.sv
// HyperRAM controller types: state and opcode enums, request and pad structs
`include "hyper_cfg.svh"

package hyper_pkg;

  // Core request opcodes
  typedef enum logic [1:0] {
    OP_MEM_WRITE = 2'd0,
    OP_MEM_READ  = 2'd1,
    OP_REG_WRITE = 2'd2,
    OP_REG_READ  = 2'd3
  } hyper_op_e;

  // Transaction sequencer states
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_CMD_ADDR   = 3'd1,
    ST_LATENCY    = 3'd2,
    ST_WRITE_DATA = 3'd3,
    ST_READ_DATA  = 3'd4,
    ST_CS_HOLD    = 3'd5
  } hyper_state_e;

  // Core-side request, addr is a byte address
  typedef struct packed {
    hyper_op_e                          op;
    logic [31:0]                        addr;
    logic [`HYPER_DWORD_BYTES*8-1:0]    wr_d;
    logic [`HYPER_DWORD_BYTES-1:0]      byte_en;
    logic [`HYPER_DWORDS_W-1:0]         num_dwords;
  } hyper_req_t;

  // Pad outputs, enables are active low (high means input)
  typedef struct packed {
    logic [7:0] dq;
    logic       dq_oe_l;
    logic       rwds;
    logic       rwds_oe_l;
    logic       ck;
    logic       cs_l;
    logic       rst_l;
  } hyper_pad_tx_t;

  // Pad inputs from the device
  typedef struct packed {
    logic [7:0] dq;
    logic       rwds;
  } hyper_pad_rx_t;

endpackage

// File: rtl/hyper_rx_capture.sv
// RWDS edge detection, read byte sampling and dword assembly
`timescale 1ns/1ns
`include "hyper_cfg.svh"

module hyper_rx_capture (
  input  logic                              clk,
  input  logic                              read_run,
  input  logic                              rwds,
  input  logic [7:0]                        dq,
  output logic [`HYPER_DWORD_BYTES*8-1:0]   rd_d,
  output logic                              dword_done
);

  localparam int DW_W  = `HYPER_DWORD_BYTES * 8;
  localparam int CNT_W = $clog2(`HYPER_DWORD_BYTES);

  logic               rwds_d;
  logic               wait_edge;
  logic               fall_slot;
  logic               sample;
  logic [CNT_W-1:0]   byte_cnt;
  logic [DW_W-1:0]    shift;

  // ------------------------------------------------------------
  // Strobe tracking
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    rwds_d <= rwds;
    sample <= 1'b0;
    if (!read_run) begin
      wait_edge <= 1'b1;
      fall_slot <= 1'b0;
    end else if (wait_edge) begin
      // Rising RWDS opens a byte pair
      if (rwds && !rwds_d) begin
        wait_edge <= 1'b0;
        fall_slot <= 1'b0;
        sample    <= 1'b1;
      end
    end else begin
      fall_slot <= 1'b1;
      // Falling-edge byte two cycles after the rising one
      if (fall_slot) begin
        wait_edge <= 1'b1;
        sample    <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Byte assembly, first byte lands in the top
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    dword_done <= 1'b0;
    if (!read_run) begin
      byte_cnt <= '0;
    end else if (sample) begin
      shift    <= {shift[DW_W-9:0], dq};
      byte_cnt <= byte_cnt + CNT_W'(1);
      if (byte_cnt == CNT_W'(`HYPER_DWORD_BYTES - 1)) begin
        rd_d       <= {shift[DW_W-9:0], dq};
        dword_done <= 1'b1;
        byte_cnt   <= '0;
      end
    end
  end

endmodule

// File: rtl/hyper_seq_fsm.sv
// HyperRAM transaction FSM: command, latency, data and chip-select hold phases
`timescale 1ns/1ns
`include "hyper_cfg.svh"

module hyper_seq_fsm (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_valid,
  input  hyper_pkg::hyper_op_e          op,
  input  logic [`HYPER_DWORDS_W-1:0]    num_dwords,
  input  logic [`HYPER_LAT_W-1:0]       latency_1x,
  input  logic [`HYPER_LAT_W-1:0]       latency_2x,
  input  logic                          rwds_sample,
  input  logic                          phase_tick,
  input  logic                          expired,
  input  logic                          dword_done,
  output logic                          load,
  output logic [`HYPER_LAT_W-1:0]       count,
  output logic                          run,
  output logic                          shift_ca,
  output logic                          shift_data,
  output logic                          read_run,
  output logic                          dq_oe_l,
  output logic                          rwds_oe_l,
  output logic                          cs,
  output logic                          busy
);

  hyper_pkg::hyper_state_e            state;
  hyper_pkg::hyper_state_e            state_next;
  hyper_pkg::hyper_op_e               op_q;
  logic [`HYPER_DWORDS_W-1:0]         dwords_left;
  logic [1:0]                         hold_cnt;
  logic                               is_write;
  logic                               hold_last;

  assign is_write = (op_q == hyper_pkg::OP_MEM_WRITE) || (op_q == hyper_pkg::OP_REG_WRITE);
  // Third hold cycle, chip select already released
  assign hold_last = (state == hyper_pkg::ST_CS_HOLD) && (hold_cnt == 2'd2);

  // ------------------------------------------------------------
  // Next state and timer loads
  // ------------------------------------------------------------
  always_comb begin
    state_next = state;
    load       = 1'b0;
    count      = '0;
    case (state)
      hyper_pkg::ST_IDLE: begin
        if (req_valid) begin
          state_next = hyper_pkg::ST_CMD_ADDR;
          load       = 1'b1;
          count      = `HYPER_LAT_W'(`HYPER_CA_BYTES);
        end
      end
      hyper_pkg::ST_CMD_ADDR: begin
        if (expired) begin
          load = 1'b1;
          case (op_q)
            // Zero latency, data straight after CA
            hyper_pkg::OP_REG_WRITE: begin
              state_next = hyper_pkg::ST_WRITE_DATA;
              count      = `HYPER_LAT_W'(`HYPER_REG_BYTES);
            end
            // RWDS high during CA asks for double latency
            hyper_pkg::OP_MEM_WRITE: begin
              state_next = hyper_pkg::ST_LATENCY;
              count      = rwds_sample ? latency_2x : latency_1x;
            end
            // Reads are paced by the device RWDS strobe
            default: begin
              state_next = hyper_pkg::ST_READ_DATA;
              count      = `HYPER_LAT_W'(`HYPER_READ_WAIT);
            end
          endcase
        end
      end
      hyper_pkg::ST_LATENCY: begin
        if (expired) begin
          state_next = hyper_pkg::ST_WRITE_DATA;
          load       = 1'b1;
          count      = `HYPER_LAT_W'(`HYPER_DWORD_BYTES);
        end
      end
      hyper_pkg::ST_WRITE_DATA: begin
        if (expired) begin
          state_next = hyper_pkg::ST_CS_HOLD;
        end
      end
      hyper_pkg::ST_READ_DATA: begin
        if (dword_done) begin
          if (dwords_left == `HYPER_DWORDS_W'(1)) begin
            state_next = hyper_pkg::ST_CS_HOLD;
          end else begin
            load  = 1'b1;
            count = `HYPER_LAT_W'(`HYPER_READ_WAIT);
          end
        end else if (expired) begin
          // No strobe from the device, give up on the burst
          state_next = hyper_pkg::ST_CS_HOLD;
        end
      end
      hyper_pkg::ST_CS_HOLD: begin
        if (hold_last) begin
          state_next = hyper_pkg::ST_IDLE;
        end
      end
      default: state_next = hyper_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= hyper_pkg::ST_IDLE;
      hold_cnt <= 2'd0;
    end else begin
      state <= state_next;
      if (state == hyper_pkg::ST_CS_HOLD) begin
        hold_cnt <= hold_cnt + 2'd1;
      end else begin
        hold_cnt <= 2'd0;
      end
    end
  end

  // Request fields kept for the whole transaction
  always_ff @(posedge clk) begin
    if (state == hyper_pkg::ST_IDLE && req_valid) begin
      op_q        <= op;
      dwords_left <= num_dwords;
    end else if (state == hyper_pkg::ST_READ_DATA && dword_done) begin
      dwords_left <= dwords_left - `HYPER_DWORDS_W'(1);
    end
  end

  // ------------------------------------------------------------
  // Phase controls and pad direction
  // ------------------------------------------------------------
  assign run = (state == hyper_pkg::ST_CMD_ADDR) || (state == hyper_pkg::ST_LATENCY) ||
               (state == hyper_pkg::ST_WRITE_DATA) || (state == hyper_pkg::ST_READ_DATA);
  assign shift_ca   = phase_tick && (state == hyper_pkg::ST_CMD_ADDR);
  assign shift_data = phase_tick && (state == hyper_pkg::ST_WRITE_DATA);
  assign read_run   = (state == hyper_pkg::ST_READ_DATA);
  assign cs         = (state != hyper_pkg::ST_IDLE) && !hold_last;
  assign busy       = (state != hyper_pkg::ST_IDLE);

  always_comb begin
    case (state)
      // CA out, RWDS in for the latency sample
      hyper_pkg::ST_CMD_ADDR: begin
        dq_oe_l   = 1'b0;
        rwds_oe_l = 1'b1;
      end
      hyper_pkg::ST_LATENCY, hyper_pkg::ST_WRITE_DATA: begin
        dq_oe_l   = 1'b0;
        rwds_oe_l = 1'b0;
      end
      // Keep the last write byte on the pads until CS rises
      hyper_pkg::ST_CS_HOLD: begin
        dq_oe_l   = !is_write;
        rwds_oe_l = !is_write;
      end
      default: begin
        dq_oe_l   = 1'b1;
        rwds_oe_l = 1'b1;
      end
    endcase
  end

endmodule

// File: rtl/hyper_tx_shift.sv
// Command-address and write-data byte shifters with byte-enable mask
`timescale 1ns/1ns
`include "hyper_cfg.svh"

module hyper_tx_shift (
  input  logic                    clk,
  input  logic                    req_valid,
  input  hyper_pkg::hyper_req_t   req,
  input  logic                    shift_ca,
  input  logic                    shift_data,
  output logic [7:0]              tx_byte,
  output logic                    tx_mask
);

  localparam int CA_W = `HYPER_CA_BYTES * 8;
  localparam int DW_W = `HYPER_DWORD_BYTES * 8;

  logic [CA_W-1:0]                ca_word;
  logic [CA_W-1:0]                ca_sr;
  logic [DW_W-1:0]                data_sr;
  logic [`HYPER_DWORD_BYTES-1:0]  be_sr;
  logic                           is_read;
  logic                           is_reg;

  assign is_read = (req.op == hyper_pkg::OP_MEM_READ) || (req.op == hyper_pkg::OP_REG_READ);
  assign is_reg  = (req.op == hyper_pkg::OP_REG_WRITE) || (req.op == hyper_pkg::OP_REG_READ);

  // ------------------------------------------------------------
  // CA packing: R/W#, space, linear burst, row, column
  // ------------------------------------------------------------
  always_comb begin
    if (is_reg) begin
      // Register space takes the address as is
      ca_word = {is_read, 1'b1, 1'b1, req.addr[31:3], 13'd0, req.addr[2:0]};
    end else begin
      // Byte address to 16-bit word address, always dword aligned
      ca_word = {is_read, 1'b0, 1'b1, req.addr[30:2], 13'd0, req.addr[1:0], 1'b0};
    end
  end

  // MSB first for both CA and data
  always_ff @(posedge clk) begin
    if (req_valid) begin
      ca_sr   <= ca_word;
      data_sr <= req.wr_d;
      be_sr   <= req.byte_en;
      tx_mask <= 1'b0;
    end else begin
      if (shift_ca) begin
        tx_byte <= ca_sr[CA_W-1 -: 8];
        ca_sr   <= {ca_sr[CA_W-9:0], 8'h00};
      end
      if (shift_data) begin
        tx_byte <= data_sr[DW_W-1 -: 8];
        data_sr <= {data_sr[DW_W-9:0], 8'h00};
        tx_mask <= be_sr[`HYPER_DWORD_BYTES-1];
        be_sr   <= {be_sr[`HYPER_DWORD_BYTES-2:0], 1'b0};
      end
    end
  end

endmodule

// File: testbench/hyper_golden.txt
// op addr wr_d byte_en num_dwords, then one expected word per dword for reads
// op 0 mem write, 1 mem read, 2 reg write, 3 reg read, FF ends the list
0 00000010 A1B2C3D4 F 1
1 00000010 00000000 0 1 A1B2C3D4
0 00000010 11223344 5 1
1 00000010 00000000 0 1 A122C344
0 00000020 CAFE0001 F 1
0 00000024 CAFE0002 F 1
0 00000028 CAFE0003 F 1
1 00000020 00000000 0 3 CAFE0001 CAFE0002 CAFE0003
1 00000040 00000000 0 1 1A1B1819
2 00000001 BEEF0000 F 1
3 00000001 00000000 0 1 BEEF0000
3 00000002 00000000 0 1 8F1F0000
FF

// File: testbench/hyperram_model.sv
// Behavioral HyperRAM: CA decode, masked writes, strobed reads and four registers
`timescale 1ns/1ns

module hyperram_model #(
  parameter int WR_LAT = 6,
  parameter int RD_LAT = 6
) (
  input  logic                      clk,
  input  hyper_pkg::hyper_pad_tx_t  pad_tx,
  output hyper_pkg::hyper_pad_rx_t  pad_rx
);

  logic [7:0]  mem [256];
  logic [15:0] regs [4];
  logic [47:0] ca;
  logic [7:0]  edge_idx;
  logic        ck_prev;
  logic        ca_read;
  logic        ca_reg;
  logic [7:0]  mem_base;
  logic [1:0]  reg_idx;

  assign ca_read  = ca[47];
  assign ca_reg   = ca[46];
  // Row and column back to a byte address
  assign mem_base = {ca[21:16], ca[2:1]};
  assign reg_idx  = ca[1:0];

  // ------------------------------------------------------------
  // One step per DRAM clock edge while CS is low
  // ------------------------------------------------------------
  always @(posedge clk) begin : device
    int         i;
    logic [7:0] k;
    ck_prev <= pad_tx.ck;
    if (!pad_tx.rst_l) begin
      // Fill pattern from the whole byte address
      for (i = 0; i < 256; i++) begin
        mem[i] <= 8'(i) ^ 8'h5A;
      end
      regs[0]  <= 16'h0C81;
      regs[1]  <= 16'h0C86;
      regs[2]  <= 16'h8F1F;
      regs[3]  <= 16'h0002;
      edge_idx <= 8'd0;
      pad_rx   <= '0;
    end else if (pad_tx.cs_l) begin
      // RWDS low between transactions, so always 1x latency
      edge_idx <= 8'd0;
      pad_rx   <= '0;
    end else if (pad_tx.ck !== ck_prev) begin
      edge_idx <= edge_idx + 8'd1;
      if (edge_idx < 8'd6) begin
        ca <= {ca[39:0], pad_tx.dq};
      end else if (ca_read) begin
        // Read data, RWDS high with the rising-edge byte
        if (edge_idx >= 8'(6 + RD_LAT)) begin
          k = edge_idx - 8'(6 + RD_LAT);
          pad_rx.rwds <= ~k[0];
          if (ca_reg) begin
            pad_rx.dq <= (k == 8'd0) ? regs[reg_idx][15:8] :
                         (k == 8'd1) ? regs[reg_idx][7:0] : 8'h00;
          end else begin
            pad_rx.dq <= mem[mem_base + k];
          end
        end
      end else if (ca_reg) begin
        // Zero latency register write, high byte first
        if (edge_idx == 8'd6) begin
          regs[reg_idx][15:8] <= pad_tx.dq;
        end
        if (edge_idx == 8'd7) begin
          regs[reg_idx][7:0] <= pad_tx.dq;
        end
      end else begin
        // RWDS high masks the byte
        if (edge_idx >= 8'(6 + WR_LAT) && edge_idx < 8'(10 + WR_LAT) && !pad_tx.rwds) begin
          mem[mem_base + edge_idx - 8'(6 + WR_LAT)] <= pad_tx.dq;
        end
      end
    end
  end

endmodule

// File: testbench/tb_clock.sv
// Free-running fabric clock generator
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial clk = 1'b0;

  // Half period per toggle
  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: testbench/tb_hyper.sv
// Testbench top: golden-file requests, read checks, reset checks and watchdog
`timescale 1ns/1ns
`include "hyper_cfg.svh"

module tb_hyper;

  localparam int LAT_1X           = 6;
  localparam int LAT_2X           = 12;
  localparam int RD_LAT           = 6;
  localparam int GOLD_WORDS       = 256;
  localparam int CYCLES_PER_DWORD = 200;
  localparam int RESET_CYCLES     = 10;

  logic                       clk;
  logic                       reset;
  logic                       req_valid;
  hyper_pkg::hyper_req_t      req;
  logic [`HYPER_LAT_W-1:0]    latency_1x;
  logic [`HYPER_LAT_W-1:0]    latency_2x;
  logic [31:0]                rd_d;
  logic                       rd_rdy;
  logic                       busy;
  hyper_pkg::hyper_pad_tx_t   pad_tx;
  hyper_pkg::hyper_pad_rx_t   pad_rx;

  // Golden tokens and the words seen in one transaction
  logic [31:0]  gold [GOLD_WORDS];
  logic [31:0]  read_words [$];
  int           wd_limit;

  tb_clock #(.PERIOD_NS(4)) u_clk (.clk(clk));

  hyper_ctrl dut (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .latency_1x (latency_1x),
    .latency_2x (latency_2x),
    .rd_d       (rd_d),
    .rd_rdy     (rd_rdy),
    .busy       (busy),
    .pad_tx     (pad_tx),
    .pad_rx     (pad_rx)
  );

  hyperram_model #(.WR_LAT(LAT_1X), .RD_LAT(RD_LAT)) u_ram (
    .clk    (clk),
    .pad_tx (pad_tx),
    .pad_rx (pad_rx)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic bit is_read_op(input logic [31:0] op);
    return (op == 32'd1) || (op == 32'd3);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // One request strobe, then collect rd_d on every rd_rdy until idle
  task automatic run_request(input logic [31:0] op, input logic [31:0] addr,
                             input logic [31:0] wr_d, input logic [31:0] be,
                             input logic [31:0] n);
    while (busy) begin
      @(negedge clk);
    end
    req.op         = hyper_pkg::hyper_op_e'(op[1:0]);
    req.addr       = addr;
    req.wr_d       = wr_d;
    req.byte_en    = be[3:0];
    req.num_dwords = n[5:0];
    req_valid      = 1'b1;
    @(negedge clk);
    req_valid = 1'b0;
    read_words.delete();
    while (busy) begin
      if (rd_rdy) begin
        read_words.push_back(rd_d);
      end
      @(negedge clk);
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin : main
    int    p;
    int    n;
    int    line;
    int    total;
    string name;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    latency_1x = `HYPER_LAT_W'(LAT_1X);
    latency_2x = `HYPER_LAT_W'(LAT_2X);
    wd_limit   = 0;
    $readmemh("testbench/hyper_golden.txt", gold);

    // Count dwords for the watchdog budget
    p     = 0;
    total = 0;
    while (p < GOLD_WORDS - 5 && gold[p] != 32'hFF) begin
      n     = int'(gold[p + 4]);
      total = total + n;
      p     = p + 5 + (is_read_op(gold[p]) ? n : 0);
    end
    if (total == 0) begin
      $display("Golden file holds no transactions");
      $display("Something failed");
      $fatal(1, "Empty stimulus");
    end
    wd_limit = total * CYCLES_PER_DWORD;

    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // Idle pad and port levels after reset
    check_value("reset busy", 32'd0, 32'(busy));
    check_value("reset rd_rdy", 32'd0, 32'(rd_rdy));
    check_value("reset cs_l", 32'd1, 32'(pad_tx.cs_l));
    check_value("reset rst_l", 32'd1, 32'(pad_tx.rst_l));
    check_value("reset dq_oe_l", 32'd1, 32'(pad_tx.dq_oe_l));
    check_value("reset rwds_oe_l", 32'd1, 32'(pad_tx.rwds_oe_l));

    p    = 0;
    line = 0;
    while (p < GOLD_WORDS - 5 && gold[p] != 32'hFF) begin
      line++;
      n = int'(gold[p + 4]);
      run_request(gold[p], gold[p + 1], gold[p + 2], gold[p + 3], gold[p + 4]);
      name = $sformatf("line %0d rd_rdy count", line);
      if (is_read_op(gold[p])) begin
        check_value(name, 32'(n), 32'(read_words.size()));
        for (int i = 0; i < n; i++) begin
          name = $sformatf("line %0d word %0d", line, i);
          check_value(name, gold[p + 5 + i], read_words[i]);
        end
        p = p + 5 + n;
      end else begin
        // Writes return no data
        check_value(name, 32'd0, 32'(read_words.size()));
        p = p + 5;
      end
      name = $sformatf("line %0d rd_rdy after busy", line);
      check_value(name, 32'd0, 32'(rd_rdy));
    end

    $display("Everything OK");
    $finish;
  end

  // ------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------
  initial begin : watchdog
    wait (wd_limit != 0);
    repeat (wd_limit) @(posedge clk);
    $display("Run timed out after %0d cycles", wd_limit);
    $display("Something failed");
    $fatal(1, "Timeout");
  end

endmodule
